//--- alu_int_pipe.sv
`timescale 1ns/1ps

module alu_int_pipe (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              issue_i,
	input  alu_pkg::alu_req_t req_i,
	output alu_pkg::word_t    result_o
);
	import alu_pkg::*;

	// Number of delay registers after the compute stage
	localparam int DLY_N = PIPE_LAT - 1;

	word_t comb_res;
	word_t clz_res;
	word_t res1;
	word_t dly [DLY_N];

	// One valid bit per delay register
	logic [DLY_N-1:0] dly_vld;

	// Leading zero count, later set bits overwrite earlier ones
	// A zero operand keeps the full width
	always_comb
	begin
		clz_res = word_t'(DATA_W);
		for (int i = 0; i < DATA_W; i++)
		begin
			if (req_i.a[i])
				clz_res = word_t'(DATA_W - 1 - i);
		end
	end

	// All arithmetic wraps at the word width
	always_comb
	begin
		case (req_i.op)
			OP_ADD:  comb_res = req_i.a + req_i.b;
			OP_SUB:  comb_res = req_i.a - req_i.b;
			OP_ADDI: comb_res = req_i.a + req_i.imm;
			OP_CLZ:  comb_res = clz_res;
			default: comb_res = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
			dly_vld <= '0;
		else
			dly_vld <= {dly_vld[DLY_N-2:0], issue_i};
	end

	// ========================================
	// Compute stage and latency padding
	// ========================================

	always_ff @(posedge clk)
	begin
		if (issue_i)
			res1 <= comb_res;
		if (dly_vld[0])
			dly[0] <= res1;
		for (int k = 1; k < DLY_N; k++)
		begin
			if (dly_vld[k])
				dly[k] <= dly[k-1];
		end
	end

	// Same latency as the multiply pipe, so the control needs one chain only
	assign result_o = dly[DLY_N-1];

endmodule

//--- alu_issue_ctrl.sv
`timescale 1ns/1ps

module alu_issue_ctrl (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              not_empty_i,
	input  alu_pkg::alu_req_t head_i,
	output logic              pop_o,
	output logic              req_credit_o,
	output logic              issue_mul_o,
	output logic              issue_int_o,
	input  alu_pkg::word_t    mul_result_i,
	input  alu_pkg::word_t    int_result_i,
	input  logic              rsp_credit_i,
	output logic              rsp_valid_o,
	output alu_pkg::alu_rsp_t rsp_o
);
	import alu_pkg::*;

	// Tag that travels beside the data through the pipelines
	typedef struct packed {
		logic      valid;
		tid_t      tid;
		alu_unit_e unit;
	} tag_t;

	logic                issue;
	alu_unit_e           head_unit;
	logic [CREDIT_W-1:0] credit_q;
	tag_t                chain [PIPE_LAT];
	tag_t                chain_in;
	tag_t                chain_end;
	word_t               end_value;

	// ========================================
	// Issue decision
	// ========================================

	// Multiply family goes to the multiply pipe, everything else is integer
	always_comb
	begin
		case (head_i.op)
			OP_MUL, OP_MULI, OP_MADD, OP_MSUB, OP_NMADD: head_unit = UNIT_MUL;
			default: head_unit = UNIT_INT;
		endcase
	end

	// Holding a result slot means the pipelines never have to stall
	assign issue       = not_empty_i && (credit_q != '0);
	assign pop_o       = issue;
	assign issue_mul_o = issue && (head_unit == UNIT_MUL);
	assign issue_int_o = issue && (head_unit == UNIT_INT);

	// Downstream credits, spent at issue and returned by the sink
	always_ff @(posedge clk)
	begin
		if (rst_i)
			credit_q <= CREDIT_W'(OUT_CREDITS);
		else if (issue && !rsp_credit_i)
			credit_q <= credit_q - 1'b1;
		else if (rsp_credit_i && !issue)
			credit_q <= credit_q + 1'b1;
	end

	// Each pop frees a queue slot, hand it back upstream as a one-cycle pulse
	always_ff @(posedge clk)
	begin
		if (rst_i)
			req_credit_o <= 1'b0;
		else
			req_credit_o <= pop_o;
	end

	// ========================================
	// Tag chain and result select
	// ========================================

	assign chain_in.valid = issue;
	assign chain_in.tid   = head_i.tid;
	assign chain_in.unit  = head_unit;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < PIPE_LAT; i++)
				chain[i] <= '0;
		end
		else
		begin
			chain[0] <= chain_in;
			for (int i = 1; i < PIPE_LAT; i++)
				chain[i] <= chain[i-1];
		end
	end

	// The chain end lines up with the cycle both pipelines present their result
	assign chain_end = chain[PIPE_LAT-1];
	assign end_value = (chain_end.unit == UNIT_MUL) ? mul_result_i : int_result_i;

	always_ff @(posedge clk)
	begin
		if (rst_i)
			rsp_valid_o <= 1'b0;
		else
			rsp_valid_o <= chain_end.valid;
	end

	// Payload only loads on a live result
	always_ff @(posedge clk)
	begin
		if (chain_end.valid)
		begin
			rsp_o.tid   <= chain_end.tid;
			rsp_o.value <= end_value;
		end
	end

endmodule

//--- alu_mul_pipe.sv
`timescale 1ns/1ps

module alu_mul_pipe (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              issue_i,
	input  alu_pkg::alu_req_t req_i,
	output alu_pkg::word_t    result_o
);
	import alu_pkg::*;

	// Accumulate mode decoded once at stage 1
	typedef enum logic [1:0] {
		MODE_NONE,
		MODE_ADD,
		MODE_SUB,
		MODE_NEG
	} mul_mode_e;

	// Stage valid bits, so idle cycles leave the data registers untouched
	logic [2:0] stage_vld;

	mul_mode_e dec_mode;
	word_t     dec_mult;

	word_t     s1_a;
	word_t     s1_b;
	word_t     s1_c;
	mul_mode_e s1_mode;
	word_t     s2_prod;
	word_t     s2_c;
	mul_mode_e s2_mode;
	word_t     s3_sum;
	word_t     s4_out;

	// Immediate replaces b only for the immediate multiply
	always_comb
	begin
		dec_mult = (req_i.op == OP_MULI) ? req_i.imm : req_i.b;
		case (req_i.op)
			OP_MADD:  dec_mode = MODE_ADD;
			OP_MSUB:  dec_mode = MODE_SUB;
			OP_NMADD: dec_mode = MODE_NEG;
			default:  dec_mode = MODE_NONE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
			stage_vld <= '0;
		else
			stage_vld <= {stage_vld[1:0], issue_i};
	end

	// ========================================
	// Datapath
	// ========================================

	always_ff @(posedge clk)
	begin
		// Stage 1 captures operands and mode
		if (issue_i)
		begin
			s1_a    <= req_i.a;
			s1_b    <= dec_mult;
			s1_c    <= req_i.c;
			s1_mode <= dec_mode;
		end
		// Stage 2 keeps only the low word of the product
		if (stage_vld[0])
		begin
			s2_prod <= s1_a * s1_b;
			s2_c    <= s1_c;
			s2_mode <= s1_mode;
		end
		// Stage 3 folds in the addend, NMADD turns into c minus the product
		if (stage_vld[1])
		begin
			case (s2_mode)
				MODE_ADD: s3_sum <= s2_prod + s2_c;
				MODE_SUB: s3_sum <= s2_prod - s2_c;
				MODE_NEG: s3_sum <= s2_c - s2_prod;
				default:  s3_sum <= s2_prod;
			endcase
		end
		// Stage 4 is the output register
		if (stage_vld[2])
			s4_out <= s3_sum;
	end

	assign result_o = s4_out;

endmodule

//--- alu_op_queue.sv
`timescale 1ns/1ps

module alu_op_queue (
	input  logic             clk,
	input  logic             rst_i,
	input  logic             push_i,
	input  alu_pkg::alu_req_t push_data_i,
	input  logic             pop_i,
	output alu_pkg::alu_req_t head_o,
	output logic             not_empty_o
);
	import alu_pkg::*;

	// Entry storage
	alu_req_t mem [QUEUE_DEPTH];

	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [QUEUE_CNT_W-1:0] count;

	// Write side
	// The upstream credit rule guarantees a free slot on every push
	always_ff @(posedge clk)
	begin
		if (push_i)
			mem[wr_ptr] <= push_data_i;
	end

	// Pointers wrap at the queue depth, which need not be a power of two
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push_i)
				wr_ptr <= (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		end
	end

	// Occupancy holds when a push and a pop land in the same cycle
	always_ff @(posedge clk)
	begin
		if (rst_i)
			count <= '0;
		else if (push_i && !pop_i)
			count <= count + 1'b1;
		else if (pop_i && !push_i)
			count <= count - 1'b1;
	end

	// Head is read straight from storage, so a new entry shows one cycle after its write
	assign head_o      = mem[rd_ptr];
	assign not_empty_o = (count != '0);

endmodule

//--- alu_pkg.sv
package alu_pkg;

	// ========================================
	// Widths and depths
	// ========================================

	// Operand and result width
	localparam int DATA_W = 32;

	// Thread tag width carried with every operation
	localparam int TID_W = 4;

	// Cycles from issue to the result register input
	localparam int PIPE_LAT = 4;

	// Operation queue entries, equal to the upstream credit count
	localparam int QUEUE_DEPTH = 2;

	// Result slots granted by the downstream side after reset
	localparam int OUT_CREDITS = 4;

	// Queue pointer and occupancy widths
	localparam int QUEUE_PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

	// Downstream credit counter must hold the full grant
	localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

	// ========================================
	// Basic types
	// ========================================

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [TID_W-1:0]  tid_t;

	// Nine opcodes need four bits
	typedef enum logic [3:0] {
		OP_ADD   = 4'd0,
		OP_SUB   = 4'd1,
		OP_ADDI  = 4'd2,
		OP_MUL   = 4'd3,
		OP_MULI  = 4'd4,
		OP_MADD  = 4'd5,
		OP_MSUB  = 4'd6,
		OP_NMADD = 4'd7,
		OP_CLZ   = 4'd8
	} alu_op_e;

	// Which pipeline produces the result
	typedef enum logic {
		UNIT_INT = 1'b0,
		UNIT_MUL = 1'b1
	} alu_unit_e;

	// ========================================
	// Request and response
	// ========================================

	// One operation as it arrives from upstream
	typedef struct packed {
		alu_op_e op;
		tid_t    tid;
		word_t   a;
		word_t   b;
		word_t   c;
		word_t   imm;
	} alu_req_t;

	// One result as it leaves toward downstream
	typedef struct packed {
		tid_t  tid;
		word_t value;
	} alu_rsp_t;

endpackage

//--- alu_top.sv
`timescale 1ns/1ps

module alu_top (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              req_valid_i,
	input  alu_pkg::alu_req_t req_i,
	output logic              req_credit_o,
	output logic              rsp_valid_o,
	output alu_pkg::alu_rsp_t rsp_o,
	input  logic              rsp_credit_i
);
	import alu_pkg::*;

	// Queue to control
	alu_req_t queue_head;
	logic     queue_not_empty;
	logic     queue_pop;

	// Control to pipelines and back
	logic  issue_mul;
	logic  issue_int;
	word_t mul_result;
	word_t int_result;

	// Upstream writes land here against its credits
	alu_op_queue u_queue (
		.clk         (clk),
		.rst_i       (rst_i),
		.push_i      (req_valid_i),
		.push_data_i (req_i),
		.pop_i       (queue_pop),
		.head_o      (queue_head),
		.not_empty_o (queue_not_empty)
	);

	alu_issue_ctrl u_ctrl (
		.clk          (clk),
		.rst_i        (rst_i),
		.not_empty_i  (queue_not_empty),
		.head_i       (queue_head),
		.pop_o        (queue_pop),
		.req_credit_o (req_credit_o),
		.issue_mul_o  (issue_mul),
		.issue_int_o  (issue_int),
		.mul_result_i (mul_result),
		.int_result_i (int_result),
		.rsp_credit_i (rsp_credit_i),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_o        (rsp_o)
	);

	// Both pipelines see the queue head, only the selected one captures it
	alu_mul_pipe u_mul (
		.clk      (clk),
		.rst_i    (rst_i),
		.issue_i  (issue_mul),
		.req_i    (queue_head),
		.result_o (mul_result)
	);

	alu_int_pipe u_int (
		.clk      (clk),
		.rst_i    (rst_i),
		.issue_i  (issue_int),
		.req_i    (queue_head),
		.result_o (int_result)
	);

endmodule

//--- compile.f
alu_pkg.sv
alu_op_queue.sv
alu_mul_pipe.sv
alu_int_pipe.sv
alu_issue_ctrl.sv
alu_top.sv
tb_alu.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the ALU testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 -f compile.f --top-module tb_alu -o tb_alu_sim > build.log 2>&1 \
	&& ./obj_dir/tb_alu_sim > sim.log 2>&1 \
	&& ! grep -q "TEST RESULT: FAIL" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see build.log and sim.log"; exit 1; }

//--- tb_alu.sv
`timescale 1ns/1ps

module tb_alu;
	import alu_pkg::*;

	// Polling limit in clock cycles for every wait loop
	localparam int WAIT_LIMIT = 200;
	localparam int RAND_REQS  = 300;

	logic     clk;
	logic     rst_i;
	logic     req_valid_i;
	alu_req_t req_i;
	logic     req_credit_o;
	logic     rsp_valid_o;
	alu_rsp_t rsp_o;
	logic     rsp_credit_i;

	// Expected responses in request order and the cycle of each response seen
	alu_rsp_t    exp_q [$];
	int          rsp_cyc [$];
	int          cyc = 0;
	int          up_credits;
	int          sent;
	int          rsp_count;
	int          credit_pulses;
	int          pending;
	int          returned;
	logic        sink_hold;
	logic [31:0] stim_state;
	logic [31:0] sink_state;
	int          err_value;
	int          err_count;

	alu_top UUT (
		.clk          (clk),
		.rst_i        (rst_i),
		.req_valid_i  (req_valid_i),
		.req_i        (req_i),
		.req_credit_o (req_credit_o),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_o        (rsp_o),
		.rsp_credit_i (rsp_credit_i)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Cycle counter that is read only on the falling edge
	always @(posedge clk)
		cyc = cyc + 1;

	// ========================================
	// Random numbers and reference model
	// ========================================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t stim_rand();
		stim_state = xorshift(stim_state);
		return stim_state;
	endfunction

	// Expected response from the operation rules with all arithmetic modulo 2^32
	function automatic alu_rsp_t expected_rsp(input alu_req_t r);
		alu_rsp_t    e;
		logic [63:0] prod;
		word_t       mult;
		int          zeros;
		logic        seen;
		mult  = (r.op == OP_MULI) ? r.imm : r.b;
		prod  = {32'd0, r.a} * {32'd0, mult};
		zeros = 0;
		seen  = 1'b0;
		// Count zeros from the top bit down until the first one
		for (int i = DATA_W - 1; i >= 0; i--)
		begin
			if (r.a[i])
				seen = 1'b1;
			else if (!seen)
				zeros++;
		end
		e.tid = r.tid;
		case (r.op)
			OP_ADD:          e.value = r.a + r.b;
			OP_SUB:          e.value = r.a - r.b;
			OP_ADDI:         e.value = r.a + r.imm;
			OP_MUL, OP_MULI: e.value = prod[31:0];
			OP_MADD:         e.value = prod[31:0] + r.c;
			OP_MSUB:         e.value = prod[31:0] - r.c;
			OP_NMADD:        e.value = r.c - prod[31:0];
			OP_CLZ:          e.value = word_t'(zeros);
			default:         e.value = '0;
		endcase
		return e;
	endfunction

	function automatic alu_req_t make_req(input alu_op_e op, input tid_t tid, input word_t a,
			input word_t b, input word_t c, input word_t imm);
		alu_req_t r;
		r.op  = op;
		r.tid = tid;
		r.a   = a;
		r.b   = b;
		r.c   = c;
		r.imm = imm;
		return r;
	endfunction

	function automatic alu_req_t random_req();
		alu_req_t r;
		r.op  = alu_op_e'(4'(stim_rand() % 9));
		r.tid = tid_t'(stim_rand());
		// A shifted operand gives the leading zero count a wide spread
		r.a   = stim_rand() >> (stim_rand() % 32);
		r.b   = stim_rand();
		r.c   = stim_rand();
		r.imm = stim_rand();
		return r;
	endfunction

	// ========================================
	// Checks
	// ========================================

	task automatic compare_rsp(input alu_rsp_t got, input alu_rsp_t exp);
		if (got.tid !== exp.tid || got.value !== exp.value)
		begin
			err_value++;
			$display("Fail at %0t ns: response tid %0d value %h, expected tid %0d value %h",
				$time, got.tid, got.value, exp.tid, exp.value);
		end
	endtask

	task automatic compare_count(input string what, input int got, input int exp);
		if (got != exp)
		begin
			err_count++;
			$display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic timeout_exit(input string what);
		$display("Timeout: nothing happened while waiting for %s", what);
		$display("Errors: %0d wrong values, %0d wrong counts", err_value, err_count);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	// ========================================
	// Response monitor and credit sink
	// ========================================

	always @(negedge clk)
	begin
		if (rst_i)
			rsp_credit_i = 1'b0;
		else
		begin
			if (req_credit_o)
				credit_pulses++;
			if (rsp_valid_o)
			begin
				rsp_count++;
				pending++;
				rsp_cyc.push_back(cyc);
				if (exp_q.size() == 0)
				begin
					err_count++;
					$display("Response at %0t ns arrived with no request outstanding", $time);
				end
				else
					compare_rsp(rsp_o, exp_q.pop_front());
				// Every response must be covered by a slot the sink granted
				if (rsp_count > OUT_CREDITS + returned)
				begin
					err_count++;
					$display("Fail at %0t ns: %0d responses against %0d granted slots",
						$time, rsp_count, OUT_CREDITS + returned);
				end
			end
			// A held slot goes back in about three cycles out of four
			sink_state = xorshift(sink_state);
			rsp_credit_i = 1'b0;
			if (!sink_hold && pending > 0 && sink_state[1:0] != 2'b00)
			begin
				rsp_credit_i = 1'b1;
				pending--;
				returned++;
			end
		end
	end

	// ========================================
	// Sender
	// ========================================

	// Waits for one falling edge and counts the upstream credit returned in that cycle
	task automatic wait_cycle();
		@(negedge clk);
		if (req_credit_o)
			up_credits++;
		if (up_credits > QUEUE_DEPTH)
		begin
			err_count++;
			$display("Fail at %0t ns: upstream credits rose to %0d", $time, up_credits);
		end
	endtask

	task automatic send_req(input alu_req_t r);
		int n;
		n = 0;
		while (up_credits == 0)
		begin
			wait_cycle();
			n++;
			if (n > WAIT_LIMIT)
				timeout_exit("an upstream credit");
		end
		req_valid_i = 1'b1;
		req_i       = r;
		up_credits--;
		sent++;
		exp_q.push_back(expected_rsp(r));
		wait_cycle();
		req_valid_i = 1'b0;
	endtask

	task automatic wait_responses(input int target);
		int n;
		n = 0;
		while (rsp_count < target)
		begin
			wait_cycle();
			n++;
			if (n > WAIT_LIMIT)
				timeout_exit("responses");
		end
	endtask

	// Idle until every response is in and every slot is back
	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 || pending != 0)
		begin
			wait_cycle();
			n++;
			if (n > WAIT_LIMIT)
				timeout_exit("outstanding responses and credits");
		end
		repeat (2) wait_cycle();
	endtask

	initial
	begin
		int base;
		int start;
		rst_i         = 1'b1;
		req_valid_i   = 1'b0;
		req_i         = '0;
		rsp_credit_i  = 1'b0;
		sink_hold     = 1'b0;
		stim_state    = 32'd56851;
		sink_state    = xorshift(32'd56851);
		up_credits    = QUEUE_DEPTH;
		sent          = 0;
		rsp_count     = 0;
		credit_pulses = 0;
		pending       = 0;
		returned      = 0;
		err_value     = 0;
		err_count     = 0;
		repeat (4) @(negedge clk);
		rst_i = 1'b0;

		// Nothing moves while the sender is idle
		repeat (6)
		begin
			wait_cycle();
			compare_count("rsp_valid_o while idle", int'(rsp_valid_o), 0);
			compare_count("req_credit_o while idle", int'(req_credit_o), 0);
		end
		compare_count("upstream credits after reset", up_credits, QUEUE_DEPTH);

		// Lone request with free queue and credits
		base  = rsp_count;
		start = cyc;
		send_req(make_req(OP_ADD, 4'd3, 32'd1, 32'd2, 32'd0, 32'd0));
		wait_responses(base + 1);
		compare_count("lone request latency", rsp_cyc[rsp_cyc.size()-1] - start, PIPE_LAT + 2);

		// Back-to-back requests come out on consecutive cycles
		wait_drain();
		base = rsp_count;
		for (int i = 0; i < OUT_CREDITS; i++)
			send_req(make_req(OP_MUL, tid_t'(i), word_t'(i + 5), 32'd7, 32'd0, 32'd0));
		wait_responses(base + OUT_CREDITS);
		for (int i = rsp_cyc.size() - OUT_CREDITS + 1; i < rsp_cyc.size(); i++)
			compare_count("cycles between streamed responses", rsp_cyc[i] - rsp_cyc[i-1], 1);

		// Directed corner cases
		wait_drain();
		send_req(make_req(OP_CLZ, 4'd1, 32'h0000_0000, 32'd0, 32'd0, 32'd0));
		send_req(make_req(OP_CLZ, 4'd2, 32'h8000_0000, 32'd0, 32'd0, 32'd0));
		send_req(make_req(OP_CLZ, 4'd3, 32'h0000_0001, 32'd0, 32'd0, 32'd0));
		send_req(make_req(OP_ADD, 4'd4, 32'hFFFF_FFFF, 32'd2, 32'd0, 32'd0));
		send_req(make_req(OP_SUB, 4'd5, 32'd0, 32'd1, 32'd0, 32'd0));
		send_req(make_req(OP_ADDI, 4'd6, 32'hFFFF_FFF0, 32'd0, 32'd0, 32'h20));
		send_req(make_req(OP_MUL, 4'd7, 32'h0001_0000, 32'h0001_0000, 32'd0, 32'd0));
		send_req(make_req(OP_MUL, 4'd8, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'd0, 32'd0));
		send_req(make_req(OP_MULI, 4'd9, 32'd12345, 32'd0, 32'd0, 32'hFFFF_FFFE));
		send_req(make_req(OP_MADD, 4'd10, 32'd6, 32'd7, 32'd100, 32'd0));
		send_req(make_req(OP_MSUB, 4'd11, 32'd3, 32'd4, 32'd20, 32'd0));
		send_req(make_req(OP_NMADD, 4'd12, 32'd5, 32'd5, 32'd10, 32'd0));
		send_req(make_req(OP_NMADD, 4'd13, 32'hFFFF_FFFF, 32'd3, 32'd1, 32'd0));
		wait_drain();

		// Random traffic with idle gaps on the request side
		for (int i = 0; i < RAND_REQS; i++)
		begin
			if (stim_rand() % 4 == 0)
				repeat (1 + stim_rand() % 3) wait_cycle();
			send_req(random_req());
		end
		wait_drain();

		// The sink keeps every slot so only the reset grant may come out
		@(posedge clk);
		sink_hold = 1'b1;
		wait_cycle();
		base = rsp_count;
		for (int i = 0; i < OUT_CREDITS + QUEUE_DEPTH; i++)
			send_req(random_req());
		repeat (20) wait_cycle();
		compare_count("responses while slots are held", rsp_count - base, OUT_CREDITS);
		@(posedge clk);
		sink_hold = 1'b0;
		wait_cycle();
		wait_drain();

		compare_count("responses", rsp_count, sent);
		compare_count("req_credit_o pulses", credit_pulses, sent);
		compare_count("upstream credits at end", up_credits, QUEUE_DEPTH);

		$display("Errors: %0d wrong values, %0d wrong counts", err_value, err_count);
		if (err_value + err_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
